//--- Makefile
RTL = hdl/spi_xip_pkg.sv hdl/apb_decode.sv hdl/xip_sequencer.sv hdl/spi_regs.sv \
      hdl/spi_shifter.sv hdl/apb_response.sv hdl/spi_xip_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+include $(RTL) --top-module spi_xip_top

sim:
	verilator --binary --timing -f flist.f --top-module tb_spi_xip
	@out="$$(./obj_dir/Vtb_spi_xip)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+include
hdl/spi_xip_pkg.sv
hdl/apb_decode.sv
hdl/xip_sequencer.sv
hdl/spi_regs.sv
hdl/spi_shifter.sv
hdl/apb_response.sv
hdl/spi_xip_top.sv
test/flash_model.sv
test/tb_spi_xip.sv

//--- hdl/apb_decode.sv
/* APB access decode */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module apb_decode (
  input  wire                   clock,
  input  wire                   reset,
  input  wire  [31:0]           paddr_i,
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire  [31:0]           pwdata_i,
  input  wire                   done_i,
  output spi_xip_pkg::apb_req_t req_o,
  output logic                  start_o
);

  import spi_xip_pkg::*;

  logic         busy_q;
  logic         in_reg;
  logic         in_flash;
  logic         take;
  access_kind_e kind;

  assign in_reg   = (paddr_i >= `SPI_REG_BASE) && (paddr_i <= `SPI_REG_LAST);
  assign in_flash = (paddr_i >= `FLASH_BASE) && (paddr_i <= `FLASH_LAST);
  assign take     = psel_i && penable_i && !busy_q;

  always_comb begin
    if (in_reg) begin
      kind = pwrite_i ? ACC_REG_WR : ACC_REG_RD;
    end else if (in_flash && !pwrite_i) begin
      kind = ACC_FLASH_RD;
    end else begin
      kind = ACC_BAD; // flash writes and unmapped addresses.
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q  <= 1'b0;
      start_o <= 1'b0;
    end else begin
      start_o <= take;
      if (take) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0; // freed by the pready pulse.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      req_o <= '{kind: kind, addr: paddr_i, wdata: pwdata_i};
    end
  end

endmodule

`default_nettype wire

//--- hdl/apb_response.sv
/* APB response stage */

`timescale 1ns/1ns
`default_nettype none

module apb_response (
  input  wire                        clock,
  input  wire                        reset,
  input  wire spi_xip_pkg::xip_result_t result_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  output logic                       done_o
);

  logic [31:0] swapped;

  // first byte on the wire goes to the lowest lane.
  assign swapped = {result_i.data[7:0], result_i.data[15:8],
                    result_i.data[23:16], result_i.data[31:24]};

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      prdata_o  <= '0;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= result_i.done;
      pslverr_o <= result_i.done && result_i.err;
      if (result_i.done) begin
        prdata_o <= result_i.err ? 32'h0 : (result_i.swap ? swapped : result_i.data);
      end
    end
  end

  assign done_o = pready_o;

endmodule

`default_nettype wire

//--- hdl/spi_regs.sv
/* SPI master register file */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module spi_regs (
  input  wire                      clock,
  input  wire                      reset,
  input  wire spi_xip_pkg::reg_req_t reg_req_i,
  input  wire                      shift_done_i,
  input  wire  [63:0]              rx_i,
  output spi_xip_pkg::reg_rsp_t    reg_rsp_o,
  output spi_xip_pkg::spi_ctrl_u   ctrl_o,
  output logic [15:0]              divider_o,
  output logic [`SPI_SS_NUM-1:0]   ss_o,
  output logic [63:0]              tx_o,
  output logic                     go_o
);

  import spi_xip_pkg::*;

  logic        ack_q;
  logic [31:0] rdata_q;
  logic        access;
  logic        wr;
  logic        busy;
  spi_ctrl_u   wr_ctrl;
  logic [31:0] rd_mux;

  assign access  = reg_req_i.stb && !ack_q;
  assign wr      = access && reg_req_i.we;
  assign busy    = ctrl_o.fields.go_bsy;
  assign wr_ctrl = reg_req_i.wdata;

  always_comb begin
    case (reg_req_i.addr)
      `REG_RX0_TX0: rd_mux = tx_o[31:0];
      `REG_RX1_TX1: rd_mux = tx_o[63:32];
      `REG_CTRL:    rd_mux = ctrl_o.raw;
      `REG_DIVIDER: rd_mux = {16'h0, divider_o};
      `REG_SS:      rd_mux = {{(32-`SPI_SS_NUM){1'b0}}, ss_o};
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q     <= 1'b0;
      go_o      <= 1'b0;
      ctrl_o    <= '0;
      divider_o <= '0;
      ss_o      <= '0;
    end else begin
      ack_q <= access;
      go_o  <= wr && (reg_req_i.addr == `REG_CTRL) && !busy && wr_ctrl.fields.go_bsy;
      if (wr && (reg_req_i.addr == `REG_CTRL) && !busy) begin
        ctrl_o <= wr_ctrl;
      end else if (shift_done_i) begin
        ctrl_o.fields.go_bsy <= 1'b0;
      end
      if (wr && (reg_req_i.addr == `REG_DIVIDER)) divider_o <= reg_req_i.wdata[15:0];
      if (wr && (reg_req_i.addr == `REG_SS)) ss_o <= reg_req_i.wdata[`SPI_SS_NUM-1:0];
    end
  end

  // data word holds tx until a transfer ends, then the received bits.
  always_ff @(posedge clock) begin
    if (shift_done_i) begin
      tx_o <= rx_i;
    end else if (wr && !busy) begin
      if (reg_req_i.addr == `REG_RX0_TX0) tx_o[31:0] <= reg_req_i.wdata;
      if (reg_req_i.addr == `REG_RX1_TX1) tx_o[63:32] <= reg_req_i.wdata;
    end
    if (access) rdata_q <= rd_mux;
  end

  assign reg_rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- hdl/spi_shifter.sv
/* SPI mode 0 shift engine */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module spi_shifter (
  input  wire                       clock,
  input  wire                       reset,
  input  wire spi_xip_pkg::spi_ctrl_u ctrl_i,
  input  wire  [15:0]               divider_i,
  input  wire  [`SPI_SS_NUM-1:0]    ss_i,
  input  wire  [63:0]               tx_i,
  input  wire                       go_i,
  input  wire                       spi_miso_i,
  output logic [63:0]               rx_o,
  output logic                      done_o,
  output logic                      spi_sck_o,
  output logic [`SPI_SS_NUM-1:0]    spi_ss_o,
  output logic                      spi_mosi_o,
  output logic                      spi_irq_o
);

  logic [15:0] div_cnt;
  logic        active;
  logic        miso_q;
  logic [63:0] shreg;
  logic [6:0]  bits_left;
  logic [6:0]  nbits;
  logic        tick;

  assign nbits = ((ctrl_i.fields.char_len == 7'd0) || (ctrl_i.fields.char_len > 7'd64)) ?
                 7'd64 : ctrl_i.fields.char_len;
  assign tick  = active && (div_cnt == divider_i); // half a bit period.

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_cnt   <= '0;
      spi_sck_o <= 1'b0;
      active    <= 1'b0;
      miso_q    <= 1'b0;
      shreg     <= '0;
      bits_left <= '0;
      done_o    <= 1'b0;
      spi_irq_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (go_i && !active) begin
        active    <= 1'b1;
        div_cnt   <= '0;
        spi_sck_o <= 1'b0;
        shreg     <= tx_i; // short transfers use the top bits.
        bits_left <= nbits;
        spi_irq_o <= 1'b0;
      end else if (tick) begin
        div_cnt   <= '0;
        spi_sck_o <= ~spi_sck_o;
        if (!spi_sck_o) begin
          miso_q <= spi_miso_i; // rising edge samples.
        end else begin
          shreg     <= {shreg[62:0], miso_q}; // falling edge shifts.
          bits_left <= bits_left - 7'd1;
          if (bits_left == 7'd1) begin
            active <= 1'b0;
            done_o <= 1'b1;
            if (ctrl_i.fields.ie) spi_irq_o <= 1'b1;
          end
        end
      end else if (active) begin
        div_cnt <= div_cnt + 16'd1;
      end
    end
  end

  assign rx_o       = shreg;
  assign spi_mosi_o = shreg[63];
  // automatic select only drives the lines during a transfer.
  assign spi_ss_o   = ~(ctrl_i.fields.ass ? (ss_i & {`SPI_SS_NUM{active}}) : ss_i);

endmodule

`default_nettype wire

//--- hdl/spi_xip_pkg.sv
/* SPI XIP shared types */

`default_nettype none

package spi_xip_pkg;

  typedef enum logic [1:0] {
    ACC_REG_WR   = 2'd0,
    ACC_REG_RD   = 2'd1,
    ACC_FLASH_RD = 2'd2,
    ACC_BAD      = 2'd3
  } access_kind_e;

  typedef struct packed {
    access_kind_e kind;
    logic [31:0]  addr;
    logic [31:0]  wdata;
  } apb_req_t;

  typedef struct packed {
    logic        stb;
    logic        we;
    logic [4:0]  addr; // byte offset into the SPI master.
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } reg_rsp_t;

  // control word, high fields first.
  typedef struct packed {
    logic [17:0] rsvd_hi;
    logic        ass;
    logic        ie;
    logic [2:0]  rsvd_mid;
    logic        go_bsy;
    logic        rsvd_lo;
    logic [6:0]  char_len; // 0 means 64.
  } spi_ctrl_t;

  typedef union packed {
    logic [31:0] raw;
    spi_ctrl_t   fields;
  } spi_ctrl_u;

  typedef struct packed {
    logic        done;
    logic        err;
    logic        swap;
    logic [31:0] data;
  } xip_result_t;

endpackage

`default_nettype wire

//--- hdl/spi_xip_top.sv
/* APB SPI flash XIP top */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module spi_xip_top (
  input  wire                     clock,
  input  wire                     reset,
  input  wire  [31:0]             paddr_i,
  input  wire                     psel_i,
  input  wire                     penable_i,
  input  wire                     pwrite_i,
  input  wire  [31:0]             pwdata_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    spi_sck_o,
  output logic [`SPI_SS_NUM-1:0]  spi_ss_o,
  output logic                    spi_mosi_o,
  input  wire                     spi_miso_i,
  output logic                    spi_irq_o
);

  import spi_xip_pkg::*;

  apb_req_t              req;
  logic                  start;
  logic                  resp_done;
  reg_req_t              reg_req;
  reg_rsp_t              reg_rsp;
  xip_result_t           result;
  spi_ctrl_u             ctrl;
  logic [15:0]           divider;
  logic [`SPI_SS_NUM-1:0] ss;
  logic [63:0]           tx;
  logic [63:0]           rx;
  logic                  go;
  logic                  shift_done;

  apb_decode i_decode (
    .clock(clock), .reset(reset), .paddr_i(paddr_i), .psel_i(psel_i),
    .penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
    .done_i(resp_done), .req_o(req), .start_o(start)
  );

  xip_sequencer i_sequencer (
    .clock(clock), .reset(reset), .req_i(req), .start_i(start),
    .reg_rsp_i(reg_rsp), .reg_req_o(reg_req), .result_o(result)
  );

  spi_regs i_regs (
    .clock(clock), .reset(reset), .reg_req_i(reg_req), .shift_done_i(shift_done),
    .rx_i(rx), .reg_rsp_o(reg_rsp), .ctrl_o(ctrl), .divider_o(divider),
    .ss_o(ss), .tx_o(tx), .go_o(go)
  );

  spi_shifter i_shifter (
    .clock(clock), .reset(reset), .ctrl_i(ctrl), .divider_i(divider), .ss_i(ss),
    .tx_i(tx), .go_i(go), .spi_miso_i(spi_miso_i), .rx_o(rx), .done_o(shift_done),
    .spi_sck_o(spi_sck_o), .spi_ss_o(spi_ss_o), .spi_mosi_o(spi_mosi_o),
    .spi_irq_o(spi_irq_o)
  );

  apb_response i_response (
    .clock(clock), .reset(reset), .result_i(result), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o), .done_o(resp_done)
  );

endmodule

`default_nettype wire

//--- hdl/xip_sequencer.sv
/* register bus and flash read sequencer */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module xip_sequencer (
  input  wire                      clock,
  input  wire                      reset,
  input  wire spi_xip_pkg::apb_req_t req_i,
  input  wire                      start_i,
  input  wire spi_xip_pkg::reg_rsp_t reg_rsp_i,
  output spi_xip_pkg::reg_req_t    reg_req_o,
  output spi_xip_pkg::xip_result_t result_o
);

  import spi_xip_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE, ST_REG, ST_DIV, ST_CTRL, ST_TX1, ST_TX0,
    ST_SS, ST_GO, ST_POLL, ST_SSN, ST_RX
  } seq_state_e;

  seq_state_e  state;
  seq_state_e  next_state;
  logic        stb_q;
  logic        bus_we;
  logic [4:0]  bus_addr;
  logic [31:0] bus_wdata;
  spi_ctrl_u   ctrl_cfg;
  spi_ctrl_u   ctrl_go;
  spi_ctrl_u   poll_word;
  logic        step_done;
  logic        finish;
  logic        bad_start;
  logic        res_done;
  logic        res_err;
  logic        res_swap;
  logic [31:0] res_data;

  always_comb begin
    ctrl_cfg.raw            = '0;
    ctrl_cfg.fields.char_len = 7'd64;
    ctrl_cfg.fields.ass      = 1'b1;
    ctrl_go                  = ctrl_cfg;
    ctrl_go.fields.go_bsy    = 1'b1;
  end

  assign poll_word = reg_rsp_i.rdata;
  assign step_done = stb_q && reg_rsp_i.ack;
  assign finish    = step_done && ((state == ST_REG) || (state == ST_RX));
  assign bad_start = (state == ST_IDLE) && start_i && (req_i.kind == ACC_BAD);

  // one register access per state.
  always_comb begin
    bus_we    = 1'b1;
    bus_addr  = '0;
    bus_wdata = '0;
    case (state)
      ST_REG: begin
        bus_we    = (req_i.kind == ACC_REG_WR);
        bus_addr  = req_i.addr[4:0];
        bus_wdata = req_i.wdata;
      end
      ST_DIV: begin
        bus_addr  = `REG_DIVIDER;
        bus_wdata = {16'h0, `FLASH_DIV};
      end
      ST_CTRL: begin
        bus_addr  = `REG_CTRL;
        bus_wdata = ctrl_cfg.raw;
      end
      ST_TX1: begin
        bus_addr  = `REG_RX1_TX1;
        bus_wdata = {`FLASH_CMD_READ, req_i.addr[23:0]}; // command, then address.
      end
      ST_TX0:  bus_addr = `REG_RX0_TX0; // clocks out the data phase.
      ST_SS: begin
        bus_addr  = `REG_SS;
        bus_wdata = 32'h1;
      end
      ST_GO: begin
        bus_addr  = `REG_CTRL;
        bus_wdata = ctrl_go.raw;
      end
      ST_POLL: begin
        bus_we   = 1'b0;
        bus_addr = `REG_CTRL;
      end
      ST_SSN:  bus_addr = `REG_SS;
      ST_RX: begin
        bus_we   = 1'b0;
        bus_addr = `REG_RX0_TX0;
      end
      default: bus_we = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      ST_DIV:  next_state = ST_CTRL;
      ST_CTRL: next_state = ST_TX1;
      ST_TX1:  next_state = ST_TX0;
      ST_TX0:  next_state = ST_SS;
      ST_SS:   next_state = ST_GO;
      ST_GO:   next_state = ST_POLL;
      ST_POLL: next_state = poll_word.fields.go_bsy ? ST_POLL : ST_SSN;
      ST_SSN:  next_state = ST_RX;
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      stb_q    <= 1'b0;
      res_done <= 1'b0;
    end else begin
      res_done <= finish || bad_start;
      if (state == ST_IDLE) begin
        if (start_i && (req_i.kind != ACC_BAD)) begin
          state <= (req_i.kind == ACC_FLASH_RD) ? ST_DIV : ST_REG;
          stb_q <= 1'b1;
        end
      end else if (stb_q) begin
        if (reg_rsp_i.ack) begin
          stb_q <= 1'b0;
          state <= next_state;
        end
      end else begin
        stb_q <= 1'b1; // start the next step.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bad_start) begin
      res_err  <= 1'b1;
      res_swap <= 1'b0;
      res_data <= '0;
    end else if (finish) begin
      res_err  <= 1'b0;
      res_swap <= (state == ST_RX);
      res_data <= reg_rsp_i.rdata;
    end
  end

  assign reg_req_o = '{stb: stb_q, we: bus_we, addr: bus_addr, wdata: bus_wdata};
  assign result_o  = '{done: res_done, err: res_err, swap: res_swap, data: res_data};

endmodule

`default_nettype wire

//--- include/spi_xip_config.svh
/* SPI XIP subsystem configuration */

`ifndef SPI_XIP_CONFIG_SVH
`define SPI_XIP_CONFIG_SVH

// slave select lines on the SPI master.
`define SPI_SS_NUM 8

// register window for direct SPI master access.
`define SPI_REG_BASE 32'h10001000
`define SPI_REG_LAST 32'h10001fff

// read-only execute-in-place flash window.
`define FLASH_BASE 32'h30000000
`define FLASH_LAST 32'h3fffffff

// SPI master register offsets, one word each.
`define REG_RX0_TX0 5'h00
`define REG_RX1_TX1 5'h04
`define REG_CTRL    5'h10
`define REG_DIVIDER 5'h14
`define REG_SS      5'h18

// flash read sequence.
`define FLASH_DIV      16'd4
`define FLASH_CMD_READ 8'h03

`endif

//--- test/flash_model.sv
/* SPI read flash model */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module flash_model (
  input  wire  spi_sck_i,
  input  wire  spi_ss_n_i,
  input  wire  spi_mosi_i,
  output logic spi_miso_o
);

  // word stored at a 24-bit flash address.
  function automatic logic [31:0] flash_word(input logic [23:0] addr);
    logic [31:0] mix;
    mix = {addr[15:0], addr[23:8]} ^ 32'h5a3c_96e1;
    return mix + {8'h00, addr};
  endfunction

  initial begin : serve
    logic [31:0] cmd;
    logic [31:0] data;
    int          nbits;
    spi_miso_o = 1'b0;
    forever begin
      @(negedge spi_ss_n_i);
      cmd   = '0;
      data  = '0;
      nbits = 0;
      while (!spi_ss_n_i) begin
        @(spi_sck_i or spi_ss_n_i);
        if (!spi_ss_n_i && spi_sck_i) begin
          if (nbits < 32) cmd = {cmd[30:0], spi_mosi_i}; // command and address.
          nbits++;
        end else if (!spi_ss_n_i && nbits >= 32) begin
          if (nbits == 32) begin
            data = (cmd[31:24] == `FLASH_CMD_READ) ? flash_word(cmd[23:0]) : 32'h0;
          end
          spi_miso_o = data[31]; // miso changes on the falling edge in mode 0.
          data       = {data[30:0], 1'b0};
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_spi_xip.sv
/* SPI XIP testbench */

`timescale 1ns/1ns
`default_nettype none

`include "spi_xip_config.svh"

module tb_spi_xip;

  localparam int PREADY_TIMEOUT = 4000;
  localparam int DRAIN_TIMEOUT  = 16;
  localparam int POLL_LIMIT     = 200;
  localparam logic [31:0] SS_MASK   = (32'h1 << `SPI_SS_NUM) - 32'h1;
  localparam logic [31:0] CTRL_LEN64 = 32'h0000_0040;
  localparam logic [31:0] CTRL_GO    = 32'h0000_0100;
  localparam logic [31:0] CTRL_IE    = 32'h0000_1000;
  localparam logic [31:0] CTRL_ASS   = 32'h0000_2000;

  typedef struct packed {
    logic [31:0] addr;
    logic        chk_data;
    logic [31:0] data;
    logic        err;
  } resp_expect_t;

  logic                   clock;
  logic                   reset;
  logic [31:0]            paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   spi_sck;
  logic [`SPI_SS_NUM-1:0] spi_ss;
  logic                   spi_mosi;
  wire                    spi_miso;
  logic                   spi_irq;

  resp_expect_t expect_mem [0:255];
  logic [7:0]   wr_idx = 8'd0;
  logic [7:0]   rd_idx = 8'd0;
  int           main_checks = 0;
  int           main_errors = 0;
  int           resp_checks = 0;
  int           resp_errors = 0;
  int           tests_run = 0;
  logic         timed_out = 1'b0;
  logic [31:0]  lfsr_state;

  spi_xip_top i_dut (
    .clock(clock), .reset(reset), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .spi_sck_o(spi_sck), .spi_ss_o(spi_ss), .spi_mosi_o(spi_mosi),
    .spi_miso_i(spi_miso), .spi_irq_o(spi_irq)
  );

  flash_model i_flash (
    .spi_sck_i(spi_sck), .spi_ss_n_i(spi_ss[0]), .spi_mosi_i(spi_mosi), .spi_miso_o(spi_miso)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // flash data arrives first byte in the lowest lane.
  function automatic logic [31:0] expected_flash_data(input logic [31:0] addr);
    logic [31:0] word;
    word = i_flash.flash_word(addr[23:0]);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  function automatic logic [31:0] reg_addr(input logic [4:0] offset);
    return `SPI_REG_BASE + {27'h0, offset};
  endfunction

  function automatic int total_errors();
    return main_errors + resp_errors;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want, output logic bad);
    bad = (got !== want);
    if (bad) $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, want);
  endtask

  task automatic record_check(input string what, input logic [31:0] got, input logic [31:0] want);
    logic bad;
    check_value(what, got, want, bad);
    main_checks++;
    if (bad) main_errors++;
  endtask

  // every response is matched against the oldest outstanding access.
  always @(negedge clock) begin : compare_response
    resp_expect_t entry;
    logic         bad;
    if (pready) begin
      if (rd_idx == wr_idx) begin
        resp_errors++;
        $display("pready_o seen at %0t ns with no access outstanding", $time);
      end else begin
        entry  = expect_mem[rd_idx];
        rd_idx = rd_idx + 8'd1;
        check_value($sformatf("pslverr_o for %h", entry.addr), {31'h0, pslverr},
                    {31'h0, entry.err}, bad);
        resp_checks++;
        if (bad) resp_errors++;
        if (entry.chk_data) begin
          check_value($sformatf("prdata_o for %h", entry.addr), prdata, entry.data, bad);
          resp_checks++;
          if (bad) resp_errors++;
        end
      end
    end
  end

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic chk_data,
                              input logic [31:0] exp_data, input logic exp_err,
                              output logic [31:0] rdata);
    int wait_cnt;
    rdata = '0;
    if (!timed_out) begin
      @(negedge clock);
      expect_mem[wr_idx] = '{addr: addr, chk_data: chk_data, data: exp_data, err: exp_err};
      wr_idx  = wr_idx + 8'd1;
      paddr   = addr;
      pwrite  = write;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clock);
      penable  = 1'b1; // access phase.
      wait_cnt = 0;
      @(negedge clock);
      while (!pready && wait_cnt < PREADY_TIMEOUT) begin
        @(negedge clock);
        wait_cnt++;
      end
      if (pready) begin
        rdata = prdata;
      end else begin
        timed_out = 1'b1;
        $display("timeout: no pready_o within %0d cycles for address %h", PREADY_TIMEOUT, addr);
      end
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] unused_rdata;
    apb_transfer(1'b1, addr, wdata, exp_err, 32'h0, exp_err, unused_rdata);
  endtask

  task automatic apb_read(input logic [31:0] addr, input logic chk_data,
                          input logic [31:0] exp_data, input logic exp_err,
                          output logic [31:0] rdata);
    apb_transfer(1'b0, addr, 32'h0, chk_data, exp_data, exp_err, rdata);
  endtask

  task automatic drain_responses();
    int n;
    n = 0;
    while (rd_idx != wr_idx && !timed_out && n < DRAIN_TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (rd_idx != wr_idx && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: responses still outstanding after %0d cycles", DRAIN_TIMEOUT);
    end
  endtask

  task automatic finish_test(input string name, input int base);
    drain_responses();
    tests_run++;
    $display("%s: done, %0d errors", name, total_errors() - base);
  endtask

  task automatic check_reset_state();
    int base;
    base = total_errors();
    record_check("pready_o after reset", {31'h0, pready}, 32'h0);
    record_check("spi_irq_o after reset", {31'h0, spi_irq}, 32'h0);
    record_check("spi_sck_o after reset", {31'h0, spi_sck}, 32'h0);
    record_check("spi_ss_o after reset", {{(32-`SPI_SS_NUM){1'b0}}, spi_ss}, SS_MASK);
    record_check("prdata_o after reset", prdata, 32'h0);
    finish_test("reset state", base);
  endtask

  task automatic readback_registers();
    int          base;
    int          i;
    logic [31:0] div;
    logic [31:0] ss;
    logic [31:0] tx0;
    logic [31:0] tx1;
    logic [31:0] rdata;
    base = total_errors();
    for (i = 0; i < 4; i++) begin
      div = rand_bits(32);
      ss  = rand_bits(32);
      tx0 = rand_bits(32);
      tx1 = rand_bits(32);
      apb_write(reg_addr(`REG_DIVIDER), div, 1'b0);
      apb_write(reg_addr(`REG_SS), ss, 1'b0);
      apb_write(reg_addr(`REG_RX0_TX0), tx0, 1'b0);
      apb_write(reg_addr(`REG_RX1_TX1), tx1, 1'b0);
      apb_read(reg_addr(`REG_DIVIDER), 1'b1, div & 32'h0000_ffff, 1'b0, rdata);
      apb_read(reg_addr(`REG_SS), 1'b1, ss & SS_MASK, 1'b0, rdata);
      apb_read(reg_addr(`REG_RX0_TX0), 1'b1, tx0, 1'b0, rdata);
      apb_read(reg_addr(`REG_RX1_TX1), 1'b1, tx1, 1'b0, rdata);
    end
    finish_test("register readback", base);
  endtask

  task automatic read_flash_words();
    int          base;
    int          i;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] rdata;
    base = total_errors();
    for (i = 0; i < 6; i++) begin
      r    = rand_bits(26);
      addr = `FLASH_BASE + {4'h0, r[25:0], 2'b00};
      apb_read(addr, 1'b1, expected_flash_data(addr), 1'b0, rdata);
      record_check("spi_ss_o after flash read", {{(32-`SPI_SS_NUM){1'b0}}, spi_ss}, SS_MASK);
    end
    finish_test("flash reads", base);
  endtask

  task automatic provoke_errors();
    int          base;
    logic [31:0] rdata;
    base = total_errors();
    apb_write(`FLASH_BASE + 32'h100, rand_bits(32), 1'b1);
    apb_read(32'h2000_0000, 1'b1, 32'h0, 1'b1, rdata);
    apb_write(`SPI_REG_LAST + 32'h1, rand_bits(32), 1'b1);
    apb_read(`FLASH_BASE - 32'h4, 1'b1, 32'h0, 1'b1, rdata);
    // the flash sequence left the divider at its fixed value.
    apb_read(reg_addr(`REG_DIVIDER), 1'b1, {16'h0, `FLASH_DIV}, 1'b0, rdata);
    finish_test("error responses", base);
  endtask

  task automatic direct_transfer();
    int          base;
    int          polls;
    logic        busy;
    logic [31:0] r;
    logic [23:0] faddr;
    logic [31:0] rdata;
    base  = total_errors();
    r     = rand_bits(22);
    faddr = {r[21:0], 2'b00};
    apb_write(reg_addr(`REG_DIVIDER), 32'h1, 1'b0);
    apb_write(reg_addr(`REG_RX1_TX1), {`FLASH_CMD_READ, faddr}, 1'b0);
    apb_write(reg_addr(`REG_RX0_TX0), 32'h0, 1'b0);
    apb_write(reg_addr(`REG_SS), 32'h1, 1'b0);
    apb_write(reg_addr(`REG_CTRL), CTRL_IE | CTRL_ASS | CTRL_GO | CTRL_LEN64, 1'b0);
    polls = 0;
    busy  = 1'b1;
    while (busy && !timed_out && polls < POLL_LIMIT) begin
      apb_read(reg_addr(`REG_CTRL), 1'b0, 32'h0, 1'b0, rdata);
      busy = ((rdata & CTRL_GO) != 32'h0);
      polls++;
    end
    if (busy && !timed_out) begin
      main_errors++;
      $display("go_bsy in ctrl was still set after %0d polls", polls);
    end
    record_check("spi_irq_o after transfer", {31'h0, spi_irq}, 32'h1);
    apb_read(reg_addr(`REG_RX0_TX0), 1'b1, i_flash.flash_word(faddr), 1'b0, rdata);
    finish_test("direct transfer", base);
  endtask

  initial begin : main
    reset      = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    lfsr_state = 32'h6b43;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_reset_state();
    if (!timed_out) readback_registers();
    if (!timed_out) read_flash_words();
    if (!timed_out) provoke_errors();
    if (!timed_out) direct_transfer();
    $display("tests %0d, checks %0d, errors %0d", tests_run, main_checks + resp_checks,
             total_errors());
    if (total_errors() == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
